// File: logic/wb_iob_params.svh
`ifndef WB_IOB_PARAMS_SVH
`define WB_IOB_PARAMS_SVH

// Bus widths.
`define WB_IOB_ADDR_W 32
`define WB_IOB_DATA_W 32
`define WB_IOB_STRB_W (`WB_IOB_DATA_W / 8)

// RAM word address width for 256 words.
`define WB_IOB_RAM_AW 8

// Address bit that picks the slave. Zero is the RAM, one the CSR block.
`define WB_IOB_SEL_BIT 12

// Byte offsets inside the CSR block.
`define WB_IOB_CSR_SCRATCH   4'h0
`define WB_IOB_CSR_FLAGS_SET 4'h4
`define WB_IOB_CSR_FLAGS_CLR 4'h8

`endif

// File: logic/wb_iob_pkg.sv
`include "wb_iob_params.svh"

package wb_iob_pkg;

   // ==============================
   // Wishbone side
   // ==============================

   typedef struct packed {
      logic [`WB_IOB_ADDR_W-1:0] addr;
      logic [`WB_IOB_STRB_W-1:0] sel;   // Byte selects.
      logic                      we;
      logic                      cyc;
      logic                      stb;
      logic [`WB_IOB_DATA_W-1:0] data;  // Write data.
   } wb_req_t;

   typedef struct packed {
      logic                      ack;
      logic [`WB_IOB_DATA_W-1:0] data;  // Read data, masked by sel.
   } wb_rsp_t;

   // ==============================
   // IOb side
   // ==============================

   // A zero wstrb marks a read.
   typedef struct packed {
      logic                      avalid;
      logic [`WB_IOB_ADDR_W-1:0] addr;
      logic [`WB_IOB_DATA_W-1:0] wdata;
      logic [`WB_IOB_STRB_W-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic                      ready;
      logic                      rvalid;
      logic [`WB_IOB_DATA_W-1:0] rdata;
   } iob_rsp_t;

endpackage

// File: logic/wb2iob_bridge.sv
`include "wb_iob_params.svh"

module wb2iob_bridge (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  wb_iob_pkg::wb_req_t  wb_req_i,
   output wb_iob_pkg::wb_rsp_t  wb_rsp_o,
   output wb_iob_pkg::iob_req_t iob_req_o,
   input  wb_iob_pkg::iob_rsp_t iob_rsp_i
);

   logic                      ack;
   logic                      avalid;
   logic [`WB_IOB_STRB_W-1:0] wstrb;
   logic                      wack;
   logic                      wack_q;
   logic [`WB_IOB_DATA_W-1:0] data_mask;

   // ==============================
   // Request path
   // ==============================

   assign ack    = iob_rsp_i.rvalid | wack_q;
   assign avalid = wb_req_i.cyc & wb_req_i.stb & ~ack;  // No new request in the ack cycle.
   assign wstrb  = wb_req_i.we ? wb_req_i.sel : '0;

   always_comb begin
      iob_req_o.avalid = avalid;
      iob_req_o.addr   = wb_req_i.addr;
      iob_req_o.wdata  = wb_req_i.data;
      iob_req_o.wstrb  = wstrb;
   end

   // ==============================
   // Response path
   // ==============================

   // Write is acked the cycle after the slave takes it.
   assign wack = avalid & iob_rsp_i.ready & (|wstrb);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wack_q <= 1'b0;
      end else begin
         wack_q <= wack;
      end
   end

   always_comb begin
      for (int i = 0; i < `WB_IOB_STRB_W; i++) begin
         data_mask[8*i +: 8] = {8{wb_req_i.sel[i]}};
      end
   end

   always_comb begin
      wb_rsp_o.ack  = ack;
      wb_rsp_o.data = iob_rsp_i.rdata & data_mask;  // Unselected lanes read as zero.
   end

endmodule

// File: logic/iob_bus_split.sv
`include "wb_iob_params.svh"

module iob_bus_split (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  wb_iob_pkg::iob_req_t req_i,
   output wb_iob_pkg::iob_rsp_t rsp_o,
   output wb_iob_pkg::iob_req_t ram_req_o,
   input  wb_iob_pkg::iob_rsp_t ram_rsp_i,
   output wb_iob_pkg::iob_req_t csr_req_o,
   input  wb_iob_pkg::iob_rsp_t csr_rsp_i
);

   logic sel_csr;
   logic ready;
   logic rd_accept;
   logic rd_csr_q;  // Owner of the outstanding read.

   assign sel_csr = req_i.addr[`WB_IOB_SEL_BIT];
   assign ready   = sel_csr ? csr_rsp_i.ready : ram_rsp_i.ready;

   // ==============================
   // Request steering
   // ==============================

   always_comb begin
      ram_req_o        = req_i;
      ram_req_o.avalid = req_i.avalid & ~sel_csr;
      csr_req_o        = req_i;
      csr_req_o.avalid = req_i.avalid & sel_csr;
   end

   assign rd_accept = req_i.avalid & ready & ~(|req_i.wstrb);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_csr_q <= 1'b0;
      end else if (rd_accept) begin
         rd_csr_q <= sel_csr;
      end
   end

   // ==============================
   // Response merge
   // ==============================

   always_comb begin
      rsp_o.ready = ready;
      if (rd_csr_q) begin
         rsp_o.rvalid = csr_rsp_i.rvalid;
         rsp_o.rdata  = csr_rsp_i.rdata;
      end else begin
         rsp_o.rvalid = ram_rsp_i.rvalid;
         rsp_o.rdata  = ram_rsp_i.rdata;
      end
   end

endmodule

// File: logic/iob_ram_slave.sv
`include "wb_iob_params.svh"

module iob_ram_slave (
   input  logic                 clk_i,
   input  wb_iob_pkg::iob_req_t req_i,
   output wb_iob_pkg::iob_rsp_t rsp_o
);

   localparam int DEPTH = 1 << `WB_IOB_RAM_AW;

   logic [`WB_IOB_DATA_W-1:0] mem [DEPTH];
   logic [`WB_IOB_RAM_AW-1:0] word_addr;
   logic                      rd_en;
   logic [`WB_IOB_DATA_W-1:0] rdata_q;
   logic                      rvalid_q;

   assign word_addr = req_i.addr[`WB_IOB_RAM_AW+1:2];  // Word addressed.
   assign rd_en     = req_i.avalid & ~(|req_i.wstrb);

   // ==============================
   // Storage
   // ==============================

   always_ff @(posedge clk_i) begin
      for (int i = 0; i < `WB_IOB_STRB_W; i++) begin
         if (req_i.avalid && req_i.wstrb[i]) begin
            mem[word_addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
         end
      end
      if (rd_en) begin
         rdata_q <= mem[word_addr];
      end
   end

   // One-cycle read pulse.
   always_ff @(posedge clk_i) begin
      rvalid_q <= rd_en;
   end

   always_comb begin
      rsp_o.ready  = 1'b1;  // Never stalls.
      rsp_o.rvalid = rvalid_q;
      rsp_o.rdata  = rdata_q;
   end

endmodule

// File: logic/iob_csr_slave.sv
`include "wb_iob_params.svh"

module iob_csr_slave (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  wb_iob_pkg::iob_req_t req_i,
   output wb_iob_pkg::iob_rsp_t rsp_o
);

   logic [3:0]                offset;
   logic                      wr_en;
   logic                      rd_en;
   logic [`WB_IOB_DATA_W-1:0] wmask;
   logic [`WB_IOB_DATA_W-1:0] wbits;
   logic [`WB_IOB_DATA_W-1:0] scratch_q;
   logic [`WB_IOB_DATA_W-1:0] flags_q;
   logic [`WB_IOB_DATA_W-1:0] rdata_q;
   logic                      rvalid_q;

   assign offset = req_i.addr[3:0];
   assign wr_en  = req_i.avalid & (|req_i.wstrb);
   assign rd_en  = req_i.avalid & ~(|req_i.wstrb);

   always_comb begin
      for (int i = 0; i < `WB_IOB_STRB_W; i++) begin
         wmask[8*i +: 8] = {8{req_i.wstrb[i]}};
      end
   end

   assign wbits = req_i.wdata & wmask;  // Strobed data bytes only.

   // ==============================
   // Registers
   // ==============================

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         scratch_q <= '0;
         flags_q   <= '0;
         rvalid_q  <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
         if (wr_en) begin
            case (offset)
               `WB_IOB_CSR_SCRATCH:   scratch_q <= (scratch_q & ~wmask) | wbits;
               `WB_IOB_CSR_FLAGS_SET: flags_q   <= flags_q | wbits;   // W1S.
               `WB_IOB_CSR_FLAGS_CLR: flags_q   <= flags_q & ~wbits;  // W1C.
               default: ;
            endcase
         end
      end
   end

   // Read data register.
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         case (offset)
            `WB_IOB_CSR_SCRATCH:   rdata_q <= scratch_q;
            `WB_IOB_CSR_FLAGS_SET: rdata_q <= flags_q;
            `WB_IOB_CSR_FLAGS_CLR: rdata_q <= flags_q;
            default:               rdata_q <= '0;
         endcase
      end
   end

   always_comb begin
      rsp_o.ready  = 1'b1;
      rsp_o.rvalid = rvalid_q;
      rsp_o.rdata  = rdata_q;
   end

endmodule

// File: logic/wb_iob_subsystem.sv
`include "wb_iob_params.svh"

module wb_iob_subsystem (
   input  logic                clk_i,
   input  logic                reset_i,
   input  wb_iob_pkg::wb_req_t wb_req_i,
   output wb_iob_pkg::wb_rsp_t wb_rsp_o
);

   wb_iob_pkg::iob_req_t bridge_req;
   wb_iob_pkg::iob_rsp_t bridge_rsp;
   wb_iob_pkg::iob_req_t ram_req;
   wb_iob_pkg::iob_rsp_t ram_rsp;
   wb_iob_pkg::iob_req_t csr_req;
   wb_iob_pkg::iob_rsp_t csr_rsp;

   // ==============================
   // Master side
   // ==============================

   wb2iob_bridge wb2iob_bridge_i (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .wb_req_i (wb_req_i),
      .wb_rsp_o (wb_rsp_o),
      .iob_req_o(bridge_req),
      .iob_rsp_i(bridge_rsp)
   );

   iob_bus_split iob_bus_split_i (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (bridge_req),
      .rsp_o    (bridge_rsp),
      .ram_req_o(ram_req),
      .ram_rsp_i(ram_rsp),
      .csr_req_o(csr_req),
      .csr_rsp_i(csr_rsp)
   );

   // ==============================
   // Slaves
   // ==============================

   iob_ram_slave iob_ram_slave_i (
      .clk_i(clk_i),
      .req_i(ram_req),
      .rsp_o(ram_rsp)
   );

   iob_csr_slave iob_csr_slave_i (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (csr_req),
      .rsp_o  (csr_rsp)
   );

endmodule

// File: test/wb_iob_subsystem_sva.sv
`include "wb_iob_params.svh"

module wb_iob_subsystem_sva (
   input logic                      clk_i,
   input logic                      reset_i,
   input wb_iob_pkg::wb_req_t       wb_req_i,
   input wb_iob_pkg::wb_rsp_t       wb_rsp_i,
   input logic [`WB_IOB_DATA_W-1:0] exp_data_i,
   input logic                      chk_en_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;
   logic        req;

   assign req = wb_req_i.cyc & wb_req_i.stb;

   // ==============================
   // Acknowledge timing
   // ==============================

   ack_idle: assert property (@(posedge clk_i) disable iff (reset_i) !req |-> !wb_rsp_i.ack)
      else begin
         fail_cnt++;
         $error("ack was high at %0t while no strobe was raised", $time);
      end

   ack_not_early: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(req) |-> !wb_rsp_i.ack)
      else begin
         fail_cnt++;
         $error("ack came in the same cycle as the strobe at %0t", $time);
      end

   ack_next: assert property (@(posedge clk_i) disable iff (reset_i) $rose(req) |=> wb_rsp_i.ack)
      else begin
         fail_cnt++;
         $error("no ack one cycle after the strobe rose, at %0t", $time);
      end

   ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_rsp_i.ack |=> !wb_rsp_i.ack)
      else begin
         fail_cnt++;
         $error("ack stayed high for more than one cycle at %0t", $time);
      end

   // ==============================
   // Read data
   // ==============================

   rd_data: assert property (@(posedge clk_i) disable iff (reset_i)
      (wb_rsp_i.ack && chk_en_i) |-> (wb_rsp_i.data == exp_data_i))
      else begin
         fail_cnt++;
         $error("mismatch at %0t: read data %h, expected %h", $time, wb_rsp_i.data, exp_data_i);
      end

endmodule

// File: test/wb_iob_subsystem_tb.sv
`include "wb_iob_params.svh"

module wb_iob_subsystem_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ACCESSES    = 75;
   localparam int CYCLE_LIMIT = 2 * (3 * ACCESSES + 10);  // Three cycles per access plus reset.
   localparam logic [31:0] CSR_BASE = 32'h1 << `WB_IOB_SEL_BIT;

   logic                clk_i;
   logic                reset_i;
   wb_iob_pkg::wb_req_t wb_req;
   wb_iob_pkg::wb_rsp_t wb_rsp;
   logic [31:0]         exp_data;  // Expected read data for the bound checks.
   logic                chk_en;

   logic [31:0] ram_m [256];  // Reference model.
   logic [31:0] scratch_m;
   logic [31:0] flags_m;
   int          seed = 32'hc6f2;
   int          cycles = 0;
   int          tests_bad = 0;
   int          errs_before = 0;

   wb_iob_subsystem wb_iob_subsystem_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .wb_req_i(wb_req),
      .wb_rsp_o(wb_rsp)
   );

   bind wb_iob_subsystem wb_iob_subsystem_sva sva_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .wb_req_i  (wb_req_i),
      .wb_rsp_i  (wb_rsp_o),
      .exp_data_i(wb_iob_subsystem_tb.exp_data),
      .chk_en_i  (wb_iob_subsystem_tb.chk_en)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   // ==============================
   // Bus access and model
   // ==============================

   function automatic logic [31:0] lanes(input logic [3:0] sel);
      logic [31:0] m;
      for (int i = 0; i < 4; i++) begin
         m[8*i +: 8] = {8{sel[i]}};
      end
      return m;
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                         input logic [3:0] sel);
      return (old & ~lanes(sel)) | (d & lanes(sel));
   endfunction

   // Inputs change 1 ns after the edge; held through the ack cycle.
   task automatic access(input logic we, input logic [31:0] addr, input logic [3:0] sel,
                         input logic [31:0] wdata, input logic [31:0] expect_rd);
      wb_req.addr = addr;
      wb_req.sel  = sel;
      wb_req.we   = we;
      wb_req.data = wdata;
      wb_req.cyc  = 1'b1;
      wb_req.stb  = 1'b1;
      exp_data    = expect_rd & lanes(sel);
      chk_en      = ~we;
      do begin
         @(posedge clk_i);
         #1;
      end while (!wb_rsp.ack);
      @(posedge clk_i);
      #1;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      chk_en     = 1'b0;
      @(posedge clk_i);  // One idle cycle between accesses.
      #1;
   endtask

   task automatic ram_write(input logic [7:0] word, input logic [3:0] sel, input logic [31:0] d);
      access(1'b1, 32'(word) << 2, sel, d, '0);
      ram_m[word] = merge(ram_m[word], d, sel);
   endtask

   task automatic ram_read(input logic [7:0] word, input logic [3:0] sel);
      access(1'b0, 32'(word) << 2, sel, '0, ram_m[word]);
   endtask

   task automatic csr_write(input logic [3:0] off, input logic [3:0] sel, input logic [31:0] d);
      access(1'b1, CSR_BASE | 32'(off), sel, d, '0);
      case (off)
         `WB_IOB_CSR_SCRATCH:   scratch_m = merge(scratch_m, d, sel);
         `WB_IOB_CSR_FLAGS_SET: flags_m   = flags_m | (d & lanes(sel));
         `WB_IOB_CSR_FLAGS_CLR: flags_m   = flags_m & ~(d & lanes(sel));
         default: ;
      endcase
   endtask

   task automatic csr_read(input logic [3:0] off, input logic [3:0] sel);
      access(1'b0, CSR_BASE | 32'(off), sel, '0, (off == `WB_IOB_CSR_SCRATCH) ? scratch_m : flags_m);
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = wb_iob_subsystem_i.sva_i.fail_cnt - errs_before;
      if (errs == 0) begin
         $display("%s: ok", name);
      end else begin
         tests_bad++;
         $display("%s: %0d assertion errors", name, errs);
      end
      errs_before = wb_iob_subsystem_i.sva_i.fail_cnt;
   endtask

   // ==============================
   // Tests
   // ==============================

   initial begin
      logic [7:0]  word;
      logic [3:0]  off;
      logic [3:0]  sel;
      logic [31:0] data;
      wb_req    = '0;
      exp_data  = '0;
      chk_en    = 1'b0;
      scratch_m = '0;
      flags_m   = '0;
      reset_i   = 1'b1;
      repeat (3) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      repeat (4) @(posedge clk_i);  // Ack must stay low on an idle bus.
      #1;
      ram_write(8'd0, 4'hf, 32'h0bad_f00d);
      ram_read(8'd0, 4'hf);
      report_test("ack timing");
      for (int i = 0; i < 16; i++) begin
         ram_write(8'(i * 17), 4'hf, $random(seed));
      end
      for (int i = 0; i < 16; i++) begin
         ram_read(8'(i * 17), 4'hf);
      end
      report_test("ram full words");
      ram_write(8'd17, 4'b0010, 32'haabb_ccdd);
      ram_write(8'd34, 4'b1001, 32'h1122_3344);
      ram_read(8'd17, 4'hf);
      ram_read(8'd34, 4'hf);
      ram_read(8'd17, 4'b0101);  // Unselected lanes read as zero.
      ram_read(8'd34, 4'b1100);
      report_test("ram partial");
      csr_write(`WB_IOB_CSR_SCRATCH, 4'hf, 32'h1234_5678);
      csr_write(`WB_IOB_CSR_SCRATCH, 4'b0100, 32'hff00_ff00);
      csr_write(`WB_IOB_CSR_SCRATCH, 4'b0001, 32'h0000_00a5);
      csr_read(`WB_IOB_CSR_SCRATCH, 4'hf);
      ram_read(8'd0, 4'hf);
      report_test("csr scratch");
      csr_write(`WB_IOB_CSR_FLAGS_SET, 4'hf, 32'h8000_0f01);
      csr_write(`WB_IOB_CSR_FLAGS_SET, 4'b0010, 32'h0000_3000);
      csr_read(`WB_IOB_CSR_FLAGS_SET, 4'hf);
      csr_write(`WB_IOB_CSR_FLAGS_CLR, 4'hf, 32'h0000_0101);
      csr_read(`WB_IOB_CSR_FLAGS_CLR, 4'hf);
      csr_read(`WB_IOB_CSR_FLAGS_SET, 4'b1000);
      report_test("csr flags");
      repeat (24) begin
         word = 8'(17 * ($unsigned($random(seed)) % 16));  // Only words written above.
         off  = 4'(4 * ($unsigned($random(seed)) % 3));
         sel  = 4'($random(seed));
         data = $random(seed);
         if (sel == 4'h0) begin
            sel = 4'hf;
         end
         case ($unsigned($random(seed)) % 4)
            0:       ram_write(word, sel, data);
            1:       ram_read(word, sel);
            2:       csr_write(off, sel, data);
            default: csr_read(off, sel);
         endcase
      end
      report_test("mixed random");
      $display("summary: 6 tests, %0d with errors, %0d assertion errors", tests_bad,
               wb_iob_subsystem_i.sva_i.fail_cnt);
      if (tests_bad == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: wb_iob_subsystem.f
+incdir+logic
logic/wb_iob_pkg.sv
logic/wb2iob_bridge.sv
logic/iob_bus_split.sv
logic/iob_ram_slave.sv
logic/iob_csr_slave.sv
logic/wb_iob_subsystem.sv
test/wb_iob_subsystem_sva.sv
test/wb_iob_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
   -f wb_iob_subsystem.f --top-module wb_iob_subsystem_tb -o wb_iob_sim
if [ $? -ne 0 ]; then
   echo "compile step returned an error"
   exit 1
fi

# Raise the error limit so the run continues past a failed assertion.
./obj_dir/wb_iob_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" "$LOG"; then
   exit 1
fi
exit 0
